// ==== logic/bus0_defs.svh ====
// Slave register reset words, LFSR seed, trojan trigger words and payload mask
`ifndef BUS0_DEFS_SVH
`define BUS0_DEFS_SVH

// Slave register reset words
// Low words of the 128-bit reference constants
`define BUS0_REG0_INIT 32'h89AB_CDEF
`define BUS0_REG1_INIT 32'h0984_4DFE
`define BUS0_REG2_INIT 32'h89AB_CDEF
`define BUS0_REG3_INIT 32'h856E_E81F

// Default LFSR seed, any nonzero value works
`define BUS0_LFSR_INIT 128'h0123_4567_89AB_CDEF_0123_4567_89AB_CDEF

// Trigger words compared against the LFSR low word
`define TROJ6_TRIGGER_1 32'h0000_0000
`define TROJ6_TRIGGER_2 32'h354A_7B6C
`define TROJ6_TRIGGER_3 32'hEAAA_D8FF
`define TROJ6_TRIGGER_4 32'h0AAA_5C5C

// Flipped into bits 1:0 of the write word on a trigger
`define TROJ6_PAYLOAD_BITS 2'b11

`endif

// ==== logic/bus0_pkg.sv ====
// Bus word, register index and bus cycle state types
package bus0_pkg;

    // One data word on the master and slave ports
    typedef logic [31:0] bus_word_t;

    // Selects one of the four slave registers
    typedef logic [1:0] reg_idx_t;

    // Five-state bus cycle
    // Walked once per accepted master request and then back to IDLE
    typedef enum logic [2:0] {
        IDLE          = 3'd0,  // Waiting for a request strobe
        ARBITRATION   = 3'd1,  // Fixed one-cycle wait, single master only
        DATA_TRANSFER = 3'd2,  // Register write happens here
        OUTPUT_DATA   = 3'd3,  // Read-back and ack
        COMPLETE      = 3'd4   // Ack drops
    } bus_state_t;

endpackage

// ==== logic/bus0_lfsr.sv ====
// 128-bit Fibonacci LFSR stepped per master request, low word output
`timescale 1ns/1ns

`include "bus0_defs.svh"

module bus0_lfsr import bus0_pkg::*; #(
    parameter logic [127:0] LFSR_INIT = `BUS0_LFSR_INIT
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      step,       // Master request strobe
    output bus_word_t lfsr_word
);

    logic [127:0] lfsr;
    logic         feedback;

    // Taps at 127, 6, 1 and 0
    assign feedback = lfsr[127] ^ lfsr[6] ^ lfsr[1] ^ lfsr[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= LFSR_INIT;
        end else if (step) begin
            lfsr <= {lfsr[126:0], feedback};  // Shift left, new bit at LSB
        end
    end

    // Only the low word reaches the trigger logic
    assign lfsr_word = lfsr[31:0];

    // An all-zero state would lock the sequence for good
    a_lfsr_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        lfsr != '0
    ) else $error("bus0_lfsr: register reached all zeros");

endmodule

// ==== logic/trojan6.sv ====
// Trigger comparators and payload bit flipper on the write data path
`timescale 1ns/1ns

`include "bus0_defs.svh"

module trojan6 import bus0_pkg::*; (
    input  bus_word_t lfsr_word,     // Low word of the LFSR
    input  bus_word_t bus_data,      // Clean master write word
    output bus_word_t bus_data_out   // Word that reaches the registers
);

    logic [3:0] trig_hit;
    logic       trig_any;
    logic [1:0] flip_mask;

    // One comparator per trigger word
    assign trig_hit[0] = (lfsr_word == `TROJ6_TRIGGER_1);
    assign trig_hit[1] = (lfsr_word == `TROJ6_TRIGGER_2);
    assign trig_hit[2] = (lfsr_word == `TROJ6_TRIGGER_3);
    assign trig_hit[3] = (lfsr_word == `TROJ6_TRIGGER_4);

    assign trig_any = |trig_hit;

    // Mask is zero unless a trigger matched
    assign flip_mask = trig_any ? `TROJ6_PAYLOAD_BITS : 2'b00;

    // Upper bits always pass untouched
    assign bus_data_out = {bus_data[31:2], bus_data[1:0] ^ flip_mask};

endmodule

// ==== logic/bus0_slave_regs.sv ====
// Four-entry slave register bank with one write port and one read port
`timescale 1ns/1ns

`include "bus0_defs.svh"

module bus0_slave_regs import bus0_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  reg_idx_t  wr_idx,
    input  bus_word_t wr_data,
    input  reg_idx_t  rd_idx,
    output bus_word_t rd_data
);

    bus_word_t regs [4];

    // Each entry comes out of reset with its own constant
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs[0] <= `BUS0_REG0_INIT;
            regs[1] <= `BUS0_REG1_INIT;
            regs[2] <= `BUS0_REG2_INIT;
            regs[3] <= `BUS0_REG3_INIT;
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;  // Only the indexed entry changes
        end
    end

    // Combinational read, sees a write on the next cycle
    assign rd_data = regs[rd_idx];

endmodule

// ==== logic/trojan6_bus0_host.sv ====
// Bus host top with cycle FSM, slave data and ack registers, LFSR, trojan and registers
`timescale 1ns/1ns

`include "bus0_defs.svh"

module trojan6_bus0_host import bus0_pkg::*; #(
    parameter logic [127:0] LFSR_INIT = `BUS0_LFSR_INIT
) (
    input  logic      clk,
    input  logic      rst,
    input  bus_word_t master_data,  // Held stable until bus_ack
    input  logic      master_req,   // One-cycle strobe
    input  reg_idx_t  reg_sel,      // Held stable until bus_ack
    output bus_word_t slave_data,
    output logic      bus_ack
);

    bus_state_t state;
    bus_word_t  lfsr_word;
    bus_word_t  bus_data_out;
    bus_word_t  rd_data;
    logic       wr_en;

    // Steps on every strobe, including those outside IDLE
    bus0_lfsr #(
        .LFSR_INIT (LFSR_INIT)
    ) u_lfsr (
        .clk       (clk),
        .rst       (rst),
        .step      (master_req),
        .lfsr_word (lfsr_word)
    );

    trojan6 u_trojan (
        .lfsr_word    (lfsr_word),
        .bus_data     (master_data),
        .bus_data_out (bus_data_out)
    );

    bus0_slave_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_idx  (reg_sel),
        .wr_data (bus_data_out),
        .rd_idx  (reg_sel),
        .rd_data (rd_data)
    );

    // Register write happens on the edge leaving DATA_TRANSFER
    assign wr_en = (state == DATA_TRANSFER);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:          if (master_req) state <= ARBITRATION;
                ARBITRATION:   state <= DATA_TRANSFER;  // No other master to wait for
                DATA_TRANSFER: state <= OUTPUT_DATA;
                OUTPUT_DATA:   state <= COMPLETE;
                COMPLETE:      state <= IDLE;
                default:       state <= IDLE;
            endcase
        end
    end

    // Read-back of the word just written, ack for exactly one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slave_data <= '0;
            bus_ack    <= 1'b0;
        end else begin
            if (state == OUTPUT_DATA) begin
                slave_data <= rd_data;
            end
            bus_ack <= (state == OUTPUT_DATA);  // Drops again in COMPLETE
        end
    end

    a_ack_single: assert property (
        @(posedge clk) disable iff (rst)
        bus_ack |=> !bus_ack
    ) else $error("trojan6_bus0_host: bus_ack high two cycles in a row");

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {IDLE, ARBITRATION, DATA_TRANSFER, OUTPUT_DATA, COMPLETE}
    ) else $error("trojan6_bus0_host: illegal bus state %0d", state);

    // Request accepted in IDLE gives an ack four cycles later
    a_ack_latency: assert property (
        @(posedge clk) disable iff (rst)
        (state == IDLE && master_req) |-> ##4 bus_ack
    ) else $error("trojan6_bus0_host: ack missing four cycles after request");

endmodule

// ==== verification/bus0_checker.sv ====
// Reference model of host, LFSR, trojan and registers with ack and data checks
`timescale 1ns/1ns

`include "bus0_defs.svh"

module bus0_checker import bus0_pkg::*; #(
    parameter logic [127:0] LFSR_INIT = `BUS0_LFSR_INIT
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      master_req,
    input  bus_word_t master_data,
    input  reg_idx_t  reg_sel,
    input  bus_word_t slave_data,
    input  logic      bus_ack,
    output int        n_pass,
    output int        n_fail,
    output logic      busy         // Request seen, ack not yet checked
);

    logic [127:0] m_lfsr;
    bus_word_t    m_regs [4];
    bus_word_t    exp_data;
    reg_idx_t     exp_idx;
    logic         exp_trig;
    logic         tx_ok;
    logic         reset_checked;
    int           cyc;
    int           due;
    int           tx_num;

    function automatic logic [127:0] lfsr_step(input logic [127:0] s);
        return {s[126:0], s[127] ^ s[6] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic is_trigger(input bus_word_t w);
        return (w == `TROJ6_TRIGGER_1) || (w == `TROJ6_TRIGGER_2) ||
               (w == `TROJ6_TRIGGER_3) || (w == `TROJ6_TRIGGER_4);
    endfunction

    // Outputs are sampled half a cycle away from the driving edge
    always @(negedge clk) begin
        if (rst) begin
            m_lfsr        = LFSR_INIT;
            m_regs[0]     = `BUS0_REG0_INIT;
            m_regs[1]     = `BUS0_REG1_INIT;
            m_regs[2]     = `BUS0_REG2_INIT;
            m_regs[3]     = `BUS0_REG3_INIT;
            busy          = 1'b0;
            reset_checked = 1'b0;
            cyc           = 0;
            tx_num        = 0;
            n_pass        = 0;
            n_fail        = 0;
        end else begin
            cyc = cyc + 1;
            if (!reset_checked) begin
                reset_checked = 1'b1;
                tx_ok = 1'b1;
                if (bus_ack !== 1'b0) begin
                    $display("Error at %0t ns: bus_ack expected 0, actual %b", $time, bus_ack);
                    tx_ok = 1'b0;
                end
                if (slave_data !== 32'h0) begin
                    $display("Error at %0t ns: slave_data expected %h, actual %h",
                             $time, 32'h0, slave_data);
                    tx_ok = 1'b0;
                end
                $display("Test reset state: %s", tx_ok ? "pass" : "fail");
                if (tx_ok) n_pass = n_pass + 1;
                else n_fail = n_fail + 1;
            end
            if (bus_ack === 1'b1) begin
                if (!busy) begin
                    $display("Error at %0t ns: bus_ack pulsed with no request outstanding",
                             $time);
                    n_fail = n_fail + 1;
                end else begin
                    tx_ok = 1'b1;
                    if (cyc != due) begin
                        $display("Error at %0t ns: bus_ack came %0d samples off its slot",
                                 $time, cyc - due);
                        tx_ok = 1'b0;
                    end
                    if (slave_data !== exp_data) begin
                        $display("Error at %0t ns: slave_data expected %h, actual %h",
                                 $time, exp_data, slave_data);
                        tx_ok = 1'b0;
                    end
                    if (tx_num == 1 && !exp_trig) begin
                        $display("Error at %0t ns: seeded trigger missed in transaction 1",
                                 $time);
                        tx_ok = 1'b0;
                    end
                    $display("Test %0d: reg %0d data %h trigger %0d: %s", tx_num, exp_idx,
                             slave_data, exp_trig, tx_ok ? "pass" : "fail");
                    if (tx_ok) n_pass = n_pass + 1;
                    else n_fail = n_fail + 1;
                    busy = 1'b0;
                end
            end else if (busy && cyc >= due) begin
                $display("Error at %0t ns: transaction %0d got no bus_ack in time", $time, tx_num);
                n_fail = n_fail + 1;
                busy = 1'b0;
            end
            if (master_req === 1'b1) begin
                m_lfsr = lfsr_step(m_lfsr);  // Every strobe steps, busy or not
                if (!busy) begin
                    tx_num   = tx_num + 1;
                    exp_idx  = reg_sel;
                    exp_trig = is_trigger(m_lfsr[31:0]);
                    m_regs[reg_sel] = exp_trig ?
                        master_data ^ 32'(`TROJ6_PAYLOAD_BITS) : master_data;
                    exp_data = m_regs[reg_sel];
                    due  = cyc + 4;  // Ack seen four samples after the strobe
                    busy = 1'b1;
                end
            end
        end
    end

endmodule

// ==== verification/tb_trojan6_bus0_host.sv ====
// Testbench top with clock, reset, random request driver, checker and timeout
`timescale 1ns/1ns

`include "bus0_defs.svh"

module tb_trojan6_bus0_host import bus0_pkg::*; ();

    localparam int NUM_DIRECTED   = 5;
    localparam int NUM_RANDOM     = 200;
    localparam int NUM_TX         = NUM_DIRECTED + NUM_RANDOM;
    localparam int RESET_CYCLES   = 10;
    localparam int CYCLE_LEN      = 5;
    localparam int MAX_GAP        = 7;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TX * (CYCLE_LEN + 1 + MAX_GAP) + 100;

    // One step gives low word {seed[30:0], fb} = 354A7B6C, with bit 127 set so fb is 0
    localparam logic [127:0] TB_LFSR_SEED = 128'h8000_0000_0000_0000_0000_0000_1AA5_3DB6;

    logic        clk;
    logic        rst;
    logic        master_req;
    bus_word_t   master_data;
    reg_idx_t    reg_sel;
    bus_word_t   slave_data;
    logic        bus_ack;
    int          n_pass;
    int          n_fail;
    logic        busy;
    logic [31:0] rnd_state;
    int          cycle_count;
    reg_idx_t    sel;
    bus_word_t   data;
    int          gap;

    trojan6_bus0_host #(
        .LFSR_INIT (TB_LFSR_SEED)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .master_data (master_data),
        .master_req  (master_req),
        .reg_sel     (reg_sel),
        .slave_data  (slave_data),
        .bus_ack     (bus_ack)
    );

    bus0_checker #(
        .LFSR_INIT (TB_LFSR_SEED)
    ) chk (
        .clk         (clk),
        .rst         (rst),
        .master_req  (master_req),
        .master_data (master_data),
        .reg_sel     (reg_sel),
        .slave_data  (slave_data),
        .bus_ack     (bus_ack),
        .n_pass      (n_pass),
        .n_fail      (n_fail),
        .busy        (busy)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rnd_state = lfsr_next(rnd_state);  // One step per bit
            v = {v[30:0], rnd_state[0]};
        end
        return v;
    endfunction

    // Strobe for one cycle, hold data and select until the ack
    task automatic run_transaction(input reg_idx_t s, input bus_word_t d);
        master_req  <= 1'b1;
        master_data <= d;
        reg_sel     <= s;
        @(posedge clk);
        master_req <= 1'b0;
        while (bus_ack !== 1'b1) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        master_req  = 1'b0;
        master_data = '0;
        reg_sel     = '0;
        rnd_state   = 32'h4301_e12d;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        for (int i = 0; i < NUM_TX; i++) begin
            if (i < NUM_DIRECTED) begin
                sel = reg_idx_t'(i % 4);  // 0 fires the trojan, then 1, 2, 3, 0 clean
            end else begin
                sel = reg_idx_t'(random_bits(2));
            end
            data = random_bits(32);
            gap  = int'(random_bits(3));
            repeat (gap) @(posedge clk);
            run_transaction(sel, data);
        end
        repeat (3) @(posedge clk);  // Checker handles the last ack
        $display("Counts: %0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0 && n_pass == NUM_TX + 1 && !busy) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/bus0_pkg.sv
logic/bus0_lfsr.sv
logic/trojan6.sv
logic/bus0_slave_regs.sv
logic/trojan6_bus0_host.sv
verification/bus0_checker.sv
verification/tb_trojan6_bus0_host.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run; the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_trojan6_bus0_host \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_trojan6_bus0_host > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && { echo "Result: PASS"; exit 0; } \
    || { echo "Result: FAIL, run ended without a verdict"; exit 1; }
